//--- all.f
source/pifo_pkg.sv
source/node_ram.sv
source/free_list.sv
source/rank_reg.sv
source/list_engine.sv
source/pifo_top.sv
dv/pifo_props.sv
dv/pifo_tb.sv

//--- dv/pifo_tb.sv
`timescale 1ns/1ps

module pifo_tb
	import pifo_pkg::*;
();

	localparam int CLK_PERIOD = 40;
	localparam int N_SORT = 12;
	localparam int N_MIX = 40;
	localparam int N_FILL = LIST_CAP + REG_DEPTH;
	// Inserts and removes over all phases
	localparam int N_OPS = 2 * N_SORT + N_FILL + 1 + N_MIX + N_FILL;
	localparam int WATCHDOG_NS = (N_OPS * (MAX_NODES + 6) + 3 + LIST_CAP + 20) * CLK_PERIOD;

	typedef struct packed
	{
		rank_t rank;
		meta_t meta;
	} entry_t;

	logic   clk;
	logic   rst;
	logic   insert;
	logic   remove;
	rank_t  rank_in;
	meta_t  meta_in;
	rank_t  rank_out;
	meta_t  meta_out;
	logic   valid_out;
	count_t num_entries;
	logic   busy;
	logic   full;

	entry_t                   model_q[$];
	int                       exp_size;
	rank_t                    exp_min;
	logic [(1 << META_W)-1:0] min_metas;
	rank_t                    last_rank;
	logic                     draining;
	int                       init_cnt;
	int                       errors;
	integer                   seed;

	pifo_top pifo_top_inst
	(
		.clk         (clk),
		.rst         (rst),
		.insert      (insert),
		.remove      (remove),
		.rank_in     (rank_in),
		.meta_in     (meta_in),
		.rank_out    (rank_out),
		.meta_out    (meta_out),
		.valid_out   (valid_out),
		.num_entries (num_entries),
		.busy        (busy),
		.full        (full)
	);

	bind pifo_top pifo_props pifo_props_inst
	(
		.clk         (clk),
		.rst         (rst),
		.insert      (insert),
		.remove      (remove),
		.rank_out    (rank_out),
		.valid_out   (valid_out),
		.num_entries (num_entries),
		.busy        (busy),
		.full        (full)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Cycles since reset release
	always @(posedge clk)
	begin
		if (rst)
			init_cnt <= 0;
		else if (init_cnt < 1000)
			init_cnt <= init_cnt + 1;
	end

	task automatic note_error(input string msg);
		errors++;
		$display("** Error at %0t ns: %s", $time, msg);
	endtask

	task automatic refresh_expect();
		exp_size = model_q.size();
		exp_min = '1;
		min_metas = '0;
		foreach (model_q[i])
		begin
			if (model_q[i].rank < exp_min)
				exp_min = model_q[i].rank;
		end
		foreach (model_q[i])
		begin
			if (model_q[i].rank == exp_min)
				min_metas[model_q[i].meta] = 1'b1;
		end
	endtask

	task automatic take_entry(input rank_t r, input meta_t m);
		int idx;
		idx = -1;
		foreach (model_q[i])
		begin
			if (idx < 0 && model_q[i].rank == r && model_q[i].meta == m)
				idx = i;
		end
		// Otherwise drop any smallest entry
		foreach (model_q[i])
		begin
			if (idx < 0 && model_q[i].rank == exp_min)
				idx = i;
		end
		if (idx >= 0)
			model_q.delete(idx);
	endtask

	// Remove first, then insert, as the register does
	always @(posedge clk)
	begin
		if (!rst)
		begin
			if (remove && valid_out)
			begin
				take_entry(rank_out, meta_out);
				last_rank = rank_out;
			end
			if (insert && !busy && !full)
				model_q.push_back(entry_t'{rank_in, meta_in});
			refresh_expect();
		end
	end

	a_min_rank: assert property (@(posedge clk) disable iff (rst)
		valid_out |-> (exp_size != 0 && rank_out == exp_min))
		else note_error($sformatf("rank_out %0d, expected %0d", $sampled(rank_out),
			$sampled(exp_min)));
	a_min_meta: assert property (@(posedge clk) disable iff (rst)
		valid_out |-> min_metas[meta_out])
		else note_error($sformatf("meta_out %0h has no entry of the smallest rank",
			$sampled(meta_out)));
	a_count: assert property (@(posedge clk) disable iff (rst)
		!busy |-> int'(num_entries) == exp_size)
		else note_error($sformatf("num_entries %0d, expected %0d", $sampled(num_entries),
			$sampled(exp_size)));
	a_init_busy: assert property (@(posedge clk) disable iff (rst)
		init_cnt <= LIST_CAP |-> busy && !valid_out)
		else note_error("busy fell or valid_out rose before the free list loaded");
	a_init_done: assert property (@(posedge clk) disable iff (rst)
		init_cnt == LIST_CAP + 1 |-> !busy && num_entries == 0)
		else note_error("busy still high or entries present after initialization");
	a_full_at_max: assert property (@(posedge clk) disable iff (rst)
		!busy && exp_size == N_FILL |-> full)
		else note_error("full is low with every node in use");
	a_full_freed: assert property (@(posedge clk) disable iff (rst)
		full && remove && valid_out |-> ##[1:10] !full)
		else note_error("full did not fall after a node was freed");
	a_drain_order: assert property (@(posedge clk) disable iff (rst)
		draining && remove && valid_out |-> rank_out >= last_rank)
		else note_error($sformatf("rank %0d removed after rank %0d", $sampled(rank_out),
			$sampled(last_rank)));

	task automatic wait_idle();
		while (busy)
			@(negedge clk);
	endtask

	task automatic insert_entry(input rank_t r, input meta_t m);
		wait_idle();
		if (!full)
		begin
			insert = 1'b1;
			rank_in = r;
			meta_in = m;
			@(negedge clk);
			insert = 1'b0;
		end
	endtask

	task automatic remove_front();
		while (!valid_out)
			@(negedge clk);
		remove = 1'b1;
		@(negedge clk);
		remove = 1'b0;
	endtask

	task automatic swap_front(input rank_t r, input meta_t m);
		while (busy || !valid_out)
			@(negedge clk);
		insert = !full;
		remove = 1'b1;
		rank_in = r;
		meta_in = m;
		@(negedge clk);
		insert = 1'b0;
		remove = 1'b0;
	endtask

	initial
	begin
		rank_t r;
		meta_t m;
		int    choice;
		int    prop_errors;
		seed = 97687;
		errors = 0;
		draining = 1'b0;
		last_rank = '0;
		exp_size = 0;
		exp_min = '1;
		min_metas = '0;
		rst = 1'b1;
		insert = 1'b0;
		remove = 1'b0;
		rank_in = '0;
		meta_in = '0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		wait_idle();

		// Small ranks give ties through eviction and refill
		for (int i = 0; i < N_SORT; i++)
		begin
			r = rank_t'($unsigned($random(seed)) % 64);
			m = meta_t'($random(seed));
			insert_entry(r, m);
		end
		last_rank = '0;
		draining = 1'b1;
		while (exp_size != 0)
			remove_front();
		draining = 1'b0;

		// Every node in use
		for (int i = 0; i < N_FILL; i++)
		begin
			r = rank_t'($random(seed));
			m = meta_t'($random(seed));
			insert_entry(r, m);
		end
		a_fill_done: assert (exp_size == N_FILL)
			else note_error($sformatf("full rose early, %0d entries accepted, expected %0d",
				exp_size, N_FILL));
		wait_idle();
		@(negedge clk);
		remove_front();
		wait_idle();

		// Register mostly full with inserts and removes on one edge
		for (int i = 0; i < N_MIX; i++)
		begin
			choice = $unsigned($random(seed)) % 3;
			r = rank_t'($random(seed));
			m = meta_t'($random(seed));
			if (exp_size == 0 || choice == 1)
				insert_entry(r, m);
			else if (choice == 0)
				remove_front();
			else
				swap_front(r, m);
		end

		while (exp_size != 0)
			remove_front();
		wait_idle();
		repeat (12) @(negedge clk);
		prop_errors = pifo_top_inst.pifo_props_inst.fail_cnt;
		$display("Checks done: %0d testbench errors, %0d property errors", errors, prop_errors);
		if (errors == 0 && prop_errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
		$display("Simulation FAILED");
		$finish;
	end

endmodule

//--- dv/pifo_props.sv
`timescale 1ns/1ps

module pifo_props
	import pifo_pkg::*;
(
	input logic   clk,
	input logic   rst,
	input logic   insert,
	input logic   remove,
	input rank_t  rank_out,
	input logic   valid_out,
	input count_t num_entries,
	input logic   busy,
	input logic   full
);

	int   fail_cnt = 0;
	logic accepted;

	assign accepted = (insert && !busy && !full) || (remove && valid_out);

	// Register empty after every reset edge
	a_reset_empty: assert property (@(posedge clk) rst |=> !valid_out)
	else
	begin
		fail_cnt++;
		$error("valid_out high after a reset edge");
	end

	a_no_insert_when_full: assert property (@(posedge clk) disable iff (rst)
		!busy |-> !(full && insert))
	else
	begin
		fail_cnt++;
		$error("insert offered while full");
	end

	a_count_bound: assert property (@(posedge clk) disable iff (rst)
		int'(num_entries) <= LIST_CAP + REG_DEPTH)
	else
	begin
		fail_cnt++;
		$error("num_entries above capacity");
	end

	// A refill never changes the front entry
	a_out_stable: assert property (@(posedge clk) disable iff (rst)
		$past(valid_out) && !$past(accepted) |-> $stable(rank_out))
	else
	begin
		fail_cnt++;
		$error("rank_out changed with no insert or remove");
	end

endmodule

//--- source/pifo_top.sv
`timescale 1ns/1ps

module pifo_top
	import pifo_pkg::*;
(
	input  logic   clk,
	input  logic   rst,
	input  logic   insert,
	input  logic   remove,
	input  rank_t  rank_in,
	input  meta_t  meta_in,
	output rank_t  rank_out,
	output meta_t  meta_out,
	output logic   valid_out,
	output count_t num_entries,
	output logic   busy,
	output logic   full
);

	reg_cnt_t reg_count;
	rank_t    max_rank;
	meta_t    max_meta;
	logic     reg_ins;
	rank_t    reg_ins_rank;
	meta_t    reg_ins_meta;

	logic   list_ins_valid;
	rank_t  list_ins_rank;
	meta_t  list_ins_meta;
	logic   list_ins_ready;
	logic   pop_valid;
	rank_t  pop_rank;
	meta_t  pop_meta;
	logic   pop_ready;
	count_t list_count;

	logic ins_acc;
	logic rem_acc;
	logic reg_full;
	logic below_max;
	logic to_reg;
	logic to_list;
	logic evict;

	assign ins_acc   = insert && !busy && !full;
	assign rem_acc   = remove && valid_out;
	assign reg_full  = (reg_count == reg_cnt_t'(REG_DEPTH));
	assign below_max = (rank_in < max_rank);

	// Admission, keeps every register entry at or below every list entry
	always_comb
	begin
		to_reg  = 1'b0;
		to_list = 1'b0;
		evict   = 1'b0;
		if (ins_acc)
		begin
			if (list_count == '0 && !reg_full)
				to_reg = 1'b1;
			else if (reg_full && !rem_acc)
			begin
				to_reg  = below_max;
				evict   = below_max;
				to_list = !below_max;
			end
			else
			begin
				to_reg  = below_max;
				to_list = !below_max;
			end
		end
	end

	// Evicted maximum or the new entry itself
	assign list_ins_valid = to_list || evict;
	assign list_ins_rank  = evict ? max_rank : rank_in;
	assign list_ins_meta  = evict ? max_meta : meta_in;

	// Refill only into a free slot not taken this edge
	assign pop_ready    = !reg_full && !to_reg;
	assign reg_ins      = to_reg || (pop_valid && pop_ready);
	assign reg_ins_rank = to_reg ? rank_in : pop_rank;
	assign reg_ins_meta = to_reg ? meta_in : pop_meta;

	assign valid_out   = (reg_count != '0);
	assign num_entries = count_t'(reg_count) + list_count;
	// Hold off inserts while a refill is owed
	assign busy = !list_ins_ready || (reg_count == '0 && list_count != '0);

	rank_reg rank_reg_inst
	(
		.clk      (clk),
		.rst      (rst),
		.ins      (reg_ins),
		.ins_rank (reg_ins_rank),
		.ins_meta (reg_ins_meta),
		.rem      (rem_acc),
		.min_rank (rank_out),
		.min_meta (meta_out),
		.max_rank (max_rank),
		.max_meta (max_meta),
		.count    (reg_count)
	);

	list_engine list_engine_inst
	(
		.clk            (clk),
		.rst            (rst),
		.list_ins_valid (list_ins_valid),
		.list_ins_rank  (list_ins_rank),
		.list_ins_meta  (list_ins_meta),
		.list_ins_ready (list_ins_ready),
		.pop_valid      (pop_valid),
		.pop_rank       (pop_rank),
		.pop_meta       (pop_meta),
		.pop_ready      (pop_ready),
		.list_count     (list_count),
		.full           (full)
	);

endmodule

//--- source/list_engine.sv
`timescale 1ns/1ps

module list_engine
	import pifo_pkg::*;
(
	input  logic   clk,
	input  logic   rst,
	input  logic   list_ins_valid,
	input  rank_t  list_ins_rank,
	input  meta_t  list_ins_meta,
	output logic   list_ins_ready,
	output logic   pop_valid,
	output rank_t  pop_rank,
	output meta_t  pop_meta,
	input  logic   pop_ready,
	output count_t list_count,
	output logic   full
);

	localparam int NODE_W = RANK_W + META_W;

	engine_state_e state;

	// Walk position with cur always the successor of prev
	node_t prev;
	node_t cur;
	// Cached successor of the head sentinel
	node_t head_next;
	node_t new_node;
	rank_t ins_rank;
	meta_t ins_meta;

	node_t             rd_addr;
	logic              data_wr_en;
	logic [NODE_W-1:0] data_wr_data;
	logic [NODE_W-1:0] data_rd_data;
	logic              link_wr_en;
	node_t             link_wr_addr;
	node_t             link_wr_data;
	node_t             link_rd_data;

	logic  fl_ready;
	logic  fl_empty;
	logic  alloc;
	node_t alloc_node;
	logic  release_en;

	logic  ins_xfer;
	logic  walk_stop;
	rank_t node_rank;

	assign list_ins_ready = (state == ENG_IDLE) && fl_ready;
	assign ins_xfer       = list_ins_valid && list_ins_ready;
	assign full           = fl_empty;

	assign node_rank = data_rd_data[META_W +: RANK_W];
	assign walk_stop = (cur == NODE_TAIL) || (node_rank > ins_rank);

	assign pop_valid = (state == ENG_POP_OUT);
	assign pop_rank  = data_rd_data[META_W +: RANK_W];
	assign pop_meta  = data_rd_data[META_W-1:0];

	assign alloc      = (state == ENG_LINK_NEW);
	assign release_en = pop_valid && pop_ready;

	// Pop keeps its address so the presented entry holds under back-pressure
	assign rd_addr = (state == ENG_POP_RD || state == ENG_POP_OUT) ? head_next : cur;

	assign data_wr_en   = (state == ENG_LINK_NEW);
	assign data_wr_data = {ins_rank, ins_meta};

	always_comb
	begin
		link_wr_en   = 1'b0;
		link_wr_addr = NODE_HEAD;
		link_wr_data = NODE_TAIL;
		case (state)
			ENG_INIT:
				link_wr_en = fl_ready;
			ENG_LINK_NEW:
			begin
				link_wr_en   = 1'b1;
				link_wr_addr = alloc_node;
				link_wr_data = cur;
			end
			ENG_LINK_PREV:
			begin
				link_wr_en   = 1'b1;
				link_wr_addr = prev;
				link_wr_data = new_node;
			end
			ENG_POP_OUT:
			begin
				// Head skips the popped node
				link_wr_en   = pop_ready;
				link_wr_data = link_rd_data;
			end
			default:
				link_wr_en = 1'b0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state      <= ENG_INIT;
			list_count <= '0;
		end
		else
		begin
			case (state)
				ENG_INIT:
					if (fl_ready)
						state <= ENG_IDLE;
				ENG_IDLE:
					if (ins_xfer)
						state <= ENG_WALK_RD;
					else if (pop_ready && list_count != '0)
						state <= ENG_POP_RD;
				ENG_WALK_RD:
					state <= ENG_WALK_CMP;
				ENG_WALK_CMP:
					state <= walk_stop ? ENG_LINK_NEW : ENG_WALK_RD;
				ENG_LINK_NEW:
					state <= ENG_LINK_PREV;
				ENG_LINK_PREV:
				begin
					list_count <= list_count + 1'b1;
					state      <= ENG_IDLE;
				end
				ENG_POP_RD:
					state <= ENG_POP_OUT;
				ENG_POP_OUT:
					if (pop_ready)
					begin
						list_count <= list_count - 1'b1;
						state      <= ENG_IDLE;
					end
				default:
					state <= ENG_INIT;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == ENG_INIT && fl_ready)
			head_next <= NODE_TAIL;
		if (ins_xfer)
		begin
			ins_rank <= list_ins_rank;
			ins_meta <= list_ins_meta;
			prev     <= NODE_HEAD;
			cur      <= head_next;
		end
		if (state == ENG_WALK_CMP && !walk_stop)
		begin
			prev <= cur;
			cur  <= link_rd_data;
		end
		if (state == ENG_LINK_NEW)
			new_node <= alloc_node;
		if (state == ENG_LINK_PREV && prev == NODE_HEAD)
			head_next <= new_node;
		if (release_en)
			head_next <= link_rd_data;
	end

	node_ram #(.DATA_W(NODE_W)) data_ram
	(
		.clk     (clk),
		.wr_en   (data_wr_en),
		.wr_addr (alloc_node),
		.wr_data (data_wr_data),
		.rd_addr (rd_addr),
		.rd_data (data_rd_data)
	);

	node_ram #(.DATA_W(L2_MAX_NODES)) link_ram
	(
		.clk     (clk),
		.wr_en   (link_wr_en),
		.wr_addr (link_wr_addr),
		.wr_data (link_wr_data),
		.rd_addr (rd_addr),
		.rd_data (link_rd_data)
	);

	free_list free_list_inst
	(
		.clk          (clk),
		.rst          (rst),
		.alloc        (alloc),
		.alloc_node   (alloc_node),
		.release_en   (release_en),
		.release_node (head_next),
		.empty        (fl_empty),
		.ready        (fl_ready)
	);

endmodule

//--- source/rank_reg.sv
`timescale 1ns/1ps

module rank_reg
	import pifo_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     ins,
	input  rank_t    ins_rank,
	input  meta_t    ins_meta,
	input  logic     rem,
	output rank_t    min_rank,
	output meta_t    min_meta,
	output rank_t    max_rank,
	output meta_t    max_meta,
	output reg_cnt_t count
);

	rank_t    rank_q [REG_DEPTH];
	meta_t    meta_q [REG_DEPTH];
	rank_t    shift_rank [REG_DEPTH];
	meta_t    shift_meta [REG_DEPTH];
	rank_t    next_rank [REG_DEPTH];
	meta_t    next_meta [REG_DEPTH];
	reg_cnt_t base_cnt;
	reg_cnt_t ins_pos;
	int       max_idx;

	// Smallest entry first
	always_comb
	begin
		for (int i = 0; i < REG_DEPTH - 1; i++)
		begin
			shift_rank[i] = rem ? rank_q[i+1] : rank_q[i];
			shift_meta[i] = rem ? meta_q[i+1] : meta_q[i];
		end
		shift_rank[REG_DEPTH-1] = rank_q[REG_DEPTH-1];
		shift_meta[REG_DEPTH-1] = meta_q[REG_DEPTH-1];

		base_cnt = (rem && count != '0) ? count - 1'b1 : count;
		// Full with no remove, so the top entry has gone to the list
		if (ins && base_cnt == reg_cnt_t'(REG_DEPTH))
			base_cnt = reg_cnt_t'(REG_DEPTH - 1);

		// Goes after any equal ranks
		ins_pos = '0;
		for (int i = 0; i < REG_DEPTH; i++)
		begin
			if (i < int'(base_cnt) && shift_rank[i] <= ins_rank)
				ins_pos = ins_pos + 1'b1;
		end

		next_rank[0] = (ins && ins_pos == '0) ? ins_rank : shift_rank[0];
		next_meta[0] = (ins && ins_pos == '0) ? ins_meta : shift_meta[0];
		for (int i = 1; i < REG_DEPTH; i++)
		begin
			if (ins && i == int'(ins_pos))
			begin
				next_rank[i] = ins_rank;
				next_meta[i] = ins_meta;
			end
			else if (ins && i > int'(ins_pos))
			begin
				next_rank[i] = shift_rank[i-1];
				next_meta[i] = shift_meta[i-1];
			end
			else
			begin
				next_rank[i] = shift_rank[i];
				next_meta[i] = shift_meta[i];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			count <= '0;
		else
			count <= base_cnt + reg_cnt_t'(ins);
	end

	always_ff @(posedge clk)
	begin
		for (int i = 0; i < REG_DEPTH; i++)
		begin
			rank_q[i] <= next_rank[i];
			meta_q[i] <= next_meta[i];
		end
	end

	always_comb
	begin
		max_idx = (count == '0) ? 0 : int'(count) - 1;
	end

	assign min_rank = rank_q[0];
	assign min_meta = meta_q[0];
	assign max_rank = rank_q[max_idx];
	assign max_meta = meta_q[max_idx];

endmodule

//--- source/free_list.sv
`timescale 1ns/1ps

module free_list
	import pifo_pkg::*;
(
	input  logic  clk,
	input  logic  rst,
	input  logic  alloc,
	output node_t alloc_node,
	input  logic  release_en,
	input  node_t release_node,
	output logic  empty,
	output logic  ready
);

	node_t  fifo_mem [MAX_NODES];
	node_t  rd_ptr;
	node_t  wr_ptr;
	count_t fill;
	node_t  load_idx;
	logic   push;
	node_t  push_node;
	logic   pop;

	// While loading, push the next unused index instead of a released one
	assign push      = !ready || release_en;
	assign push_node = ready ? release_node : load_idx;
	assign pop       = alloc && (fill != '0);

	// Fall-through head
	assign alloc_node = fifo_mem[rd_ptr];

	// Only meaningful once loaded
	assign empty = ready && (fill == '0);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			rd_ptr   <= '0;
			wr_ptr   <= '0;
			fill     <= '0;
			load_idx <= node_t'(2);
			ready    <= 1'b0;
		end
		else
		begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;

			if (push && !pop)
				fill <= fill + 1'b1;
			else if (pop && !push)
				fill <= fill - 1'b1;

			if (!ready)
			begin
				load_idx <= load_idx + 1'b1;
				// Last usable node index
				if (load_idx == node_t'(MAX_NODES - 1))
					ready <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (push)
			fifo_mem[wr_ptr] <= push_node;
	end

endmodule

//--- source/node_ram.sv
`timescale 1ns/1ps

module node_ram
	import pifo_pkg::*;
#(
	parameter int DATA_W = RANK_W + META_W
)
(
	input  logic              clk,
	input  logic              wr_en,
	input  node_t             wr_addr,
	input  logic [DATA_W-1:0] wr_data,
	input  node_t             rd_addr,
	output logic [DATA_W-1:0] rd_data
);

	logic [DATA_W-1:0] mem [MAX_NODES];

	always_ff @(posedge clk)
	begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	// Read every cycle, data one cycle later
	always_ff @(posedge clk)
	begin
		rd_data <= mem[rd_addr];
	end

endmodule

//--- source/pifo_pkg.sv
package pifo_pkg;

	// Entry fields
	localparam int RANK_W = 10;
	localparam int META_W = 10;

	// List node store
	localparam int L2_MAX_NODES = 5;
	localparam int MAX_NODES = 1 << L2_MAX_NODES;

	// Front register depth
	localparam int REG_DEPTH = 4;

	// Two nodes are taken by the sentinels
	localparam int LIST_CAP = MAX_NODES - 2;

	typedef logic [RANK_W-1:0] rank_t;
	typedef logic [META_W-1:0] meta_t;
	typedef logic [L2_MAX_NODES-1:0] node_t;

	// Enough for a full list plus a full register
	typedef logic [$clog2(LIST_CAP + REG_DEPTH + 1)-1:0] count_t;
	typedef logic [$clog2(REG_DEPTH + 1)-1:0] reg_cnt_t;

	localparam node_t NODE_HEAD = node_t'(0);
	localparam node_t NODE_TAIL = node_t'(1);

	// List engine
	typedef enum logic [2:0]
	{
		ENG_INIT,
		ENG_IDLE,
		ENG_WALK_RD,
		ENG_WALK_CMP,
		ENG_LINK_NEW,
		ENG_LINK_PREV,
		ENG_POP_RD,
		ENG_POP_OUT
	} engine_state_e;

endpackage
